//--- verilog.f
+incdir+dv
common/bp_pkg.sv
common/bp_update_if.sv
branch_history/bht_table.sv
logic/bp_resolve.sv
logic/bp_csr.sv
logic/bp_top.sv
dv/bp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bp_tb \
	-f verilog.f --Mdir obj_dir -o bp_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/bp_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

//--- dv/bp_ref.svh
/*
 * Reference model of the branch predictor
 *  - Mirror counter table, history and sweep state
 *  - Ring step, index, prediction and register read functions
 *  - Per-edge model update for the testbench
 */

`ifndef BP_REF_SVH
`define BP_REF_SVH

// ========================================
// Mirror state
// ========================================

logic [1:0]  m_pht [256];
logic [2:0]  m_ghr;
logic        m_busy;
int          m_left;
logic        m_enable;
logic [31:0] m_br_cnt;
logic [31:0] m_mis_cnt;
// Resolve stage mirror
logic        m_wb_valid;
logic        m_wb_mis;
logic [31:0] m_wb_pc;
logic        m_wb_taken;
// Pending register read
logic        m_rd_due;
logic [31:0] m_rd_exp;

// Position on the ring, strong_nt at 0 up to strong_t at 3
function automatic logic [1:0] ring_pos(input logic [1:0] st);
	return st + 2'd2;
endfunction

// Saturating move along the ring
function automatic logic [1:0] ring_step(input logic [1:0] st, input logic tk);
	logic [1:0] pos;
	pos = ring_pos(st);
	if (tk && pos != 2'd3)
		pos = pos + 2'd1;
	else if (!tk && pos != 2'd0)
		pos = pos - 2'd1;
	return pos + 2'd2;
endfunction

// Word address bits, then the two oldest history bits
function automatic logic [7:0] ref_index(input logic [31:0] pc, input logic [2:0] h);
	return {pc[7:2], h[2:1]};
endfunction

function automatic logic ref_predict(input logic [31:0] pc);
	logic [1:0] pos;
	pos = ring_pos(m_pht[ref_index(pc, m_ghr)]);
	// Upper half of the ring predicts taken
	return m_enable && !m_busy && pos[1];
endfunction

function automatic logic [31:0] ref_read(input logic [1:0] addr);
	case (addr)
		2'd0:    return {31'b0, m_enable};
		2'd1:    return {30'b0, m_enable, m_busy};
		2'd2:    return m_br_cnt;
		default: return m_mis_cnt;
	endcase
endfunction

// Full table back to weak taken
function automatic void model_fill();
	foreach (m_pht[i])
		m_pht[i] = bp_pkg::weak_t;
endfunction

function automatic void model_reset();
	model_fill();
	m_ghr      = '0;
	m_busy     = 1'b1;
	m_left     = 256;
	m_enable   = 1'b1;
	m_br_cnt   = '0;
	m_mis_cnt  = '0;
	m_wb_valid = 1'b0;
	m_wb_mis   = 1'b0;
	m_rd_due   = 1'b0;
endfunction

// Next rising edge, from inputs as the DUT will sample them
function automatic void model_edge();
	logic capture;
	logic clr;
	if (rst) begin
		model_reset();
		return;
	end
	capture = advance && is_branch;
	clr     = reg_wr && reg_addr == 2'd0 && reg_wdata[1] && !m_busy;
	// Read data uses the state before this edge
	m_rd_due = reg_rd;
	if (reg_rd)
		m_rd_exp = ref_read(reg_addr);
	// Counters see every resolved branch, busy or not
	if (reg_wr && reg_addr == 2'd2)
		m_br_cnt = '0;
	else if (m_wb_valid)
		m_br_cnt = m_br_cnt + 32'd1;
	if (reg_wr && reg_addr == 2'd3)
		m_mis_cnt = '0;
	else if (m_wb_valid && m_wb_mis)
		m_mis_cnt = m_mis_cnt + 32'd1;
	if (reg_wr && reg_addr == 2'd0)
		m_enable = reg_wdata[0];
	// Table and history
	if (m_busy) begin
		m_left = m_left - 1;
		if (m_left == 0)
			m_busy = 1'b0;
	end else if (clr) begin
		model_fill();
		m_busy = 1'b1;
		m_left = 256;
		m_ghr  = '0;
	end else if (m_wb_valid) begin
		m_pht[ref_index(m_wb_pc, m_ghr)] =
			ring_step(m_pht[ref_index(m_wb_pc, m_ghr)], m_wb_taken);
		m_ghr = {m_ghr[1:0], m_wb_taken};
	end
	// Resolve stage
	m_wb_valid = capture;
	m_wb_mis   = capture && (taken != exec_predicted);
	if (capture) begin
		m_wb_pc    = exec_pc;
		m_wb_taken = taken;
	end
endfunction

`endif

//--- dv/bp_tb.sv
/*
 * Branch predictor testbench
 *  - Clock, reset and stimulus tasks
 *  - Reference model compare on every falling edge
 *  - Reset sweep, training, random streams, enable and clear tests
 */

`timescale 1ns/1ns
`default_nettype none

module bp_tb;

	logic        clk;
	logic        rst;
	logic [31:0] fetch_pc;
	logic        predict_taken;
	logic        advance;
	logic        is_branch;
	logic [31:0] exec_pc;
	logic        taken;
	logic        exec_predicted;
	logic        mispredict;
	logic        busy;
	logic        reg_wr;
	logic        reg_rd;
	logic [1:0]  reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;

	// New random fetch address each cycle when set
	logic rand_fetch;
	int   err_count;
	int   check_count;

	`include "bp_ref.svh"

	bp_top bp_top_i (
		.clk            (clk),
		.rst            (rst),
		.fetch_pc       (fetch_pc),
		.predict_taken  (predict_taken),
		.advance        (advance),
		.is_branch      (is_branch),
		.exec_pc        (exec_pc),
		.taken          (taken),
		.exec_predicted (exec_predicted),
		.mispredict     (mispredict),
		.busy           (busy),
		.reg_wr         (reg_wr),
		.reg_rd         (reg_rd),
		.reg_addr       (reg_addr),
		.reg_wdata      (reg_wdata),
		.reg_rdata      (reg_rdata)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Checks and report
	// ========================================

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERR %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic finish_run();
		$display("Checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// Outputs settle by mid-cycle and inputs already hold their next-edge values
	always @(negedge clk) begin
		if (!rst) begin
			check_val("predict_taken", 32'(ref_predict(fetch_pc)), 32'(predict_taken));
			check_val("busy", 32'(m_busy), 32'(busy));
			check_val("mispredict", 32'(m_wb_mis), 32'(mispredict));
			if (m_rd_due)
				check_val("reg_rdata", m_rd_exp, reg_rdata);
		end
		model_edge();
	end

	// ========================================
	// Stimulus tasks
	// ========================================

	// Next drive point 2 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#2;
		if (rand_fetch)
			fetch_pc = $urandom();
	endtask

	task automatic drive_branch(input logic [31:0] pc, input logic tk, input logic pred);
		advance        = 1'b1;
		is_branch      = 1'b1;
		exec_pc        = pc;
		taken          = tk;
		exec_predicted = pred;
		tick();
	endtask

	task automatic idle_cycles(input int n);
		advance   = 1'b0;
		is_branch = 1'b0;
		repeat (n) tick();
	endtask

	// Mostly back-to-back branches on a few word slots
	task automatic run_random(input int n);
		for (int i = 0; i < n; i++) begin
			advance        = ($urandom_range(3, 0) != 0);
			is_branch      = ($urandom_range(4, 0) != 0);
			exec_pc        = $urandom() & 32'hffff_ff1c;
			taken          = 1'($urandom());
			exec_predicted = 1'($urandom());
			tick();
		end
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		reg_addr  = addr;
		reg_wdata = data;
		reg_wr    = 1'b1;
		tick();
		reg_wr = 1'b0;
	endtask

	// Data is compared by the model process one cycle later
	task automatic read_reg(input logic [1:0] addr);
		reg_addr = addr;
		reg_rd   = 1'b1;
		tick();
		reg_rd = 1'b0;
		tick();
	endtask

	task automatic wait_idle(input int limit, output int cycles);
		cycles = 0;
		while (busy && cycles < limit) begin
			tick();
			cycles++;
		end
		if (busy) begin
			$display("Timeout: busy still high after %0d cycles", limit);
			err_count++;
		end
	endtask

	// Walk all word slots at the current history
	task automatic scan_predict();
		rand_fetch = 1'b0;
		for (int i = 0; i < 64; i++) begin
			fetch_pc = {24'h0, 6'(i), 2'b00};
			tick();
		end
		rand_fetch = 1'b1;
	endtask

	task automatic read_counters();
		read_reg(2'd2);
		read_reg(2'd3);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		int cycles;
		void'($urandom(32'hfe120ec3));
		err_count      = 0;
		check_count    = 0;
		rand_fetch     = 1'b1;
		rst            = 1'b1;
		fetch_pc       = '0;
		advance        = 1'b0;
		is_branch      = 1'b0;
		exec_pc        = '0;
		taken          = 1'b0;
		exec_predicted = 1'b0;
		reg_wr         = 1'b0;
		reg_rd         = 1'b0;
		reg_addr       = 2'd0;
		reg_wdata      = '0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		// Reset sweep leaves everything weak taken
		wait_idle(300, cycles);
		check_val("reset_sweep_cycles", 32'd256, 32'(cycles));
		read_reg(2'd1);
		read_counters();
		scan_predict();

		// One address trained taken and then not taken
		rand_fetch = 1'b0;
		fetch_pc   = 32'h0000_0124;
		repeat (8) begin
			drive_branch(32'h0000_0124, 1'b1, 1'b1);
			idle_cycles(1);
		end
		repeat (8) begin
			drive_branch(32'h0000_0124, 1'b0, 1'b1);
			idle_cycles(1);
		end
		rand_fetch = 1'b1;

		// Random back-to-back streams
		run_random(400);
		idle_cycles(2);

		// Counter reads and write-to-zero
		read_counters();
		write_reg(2'd2, 32'hdead_beef);
		read_counters();
		run_random(40);
		idle_cycles(2);
		write_reg(2'd3, 32'h0);
		read_counters();

		// Predictor off while training goes on
		write_reg(2'd0, 32'h0);
		read_reg(2'd0);
		run_random(80);
		idle_cycles(2);
		read_reg(2'd1);
		write_reg(2'd0, 32'h1);
		run_random(80);
		idle_cycles(2);

		// Clear mid-run drops the updates that arrive meanwhile but counts them
		write_reg(2'd0, 32'h3);
		run_random(30);
		idle_cycles(2);
		read_reg(2'd1);
		wait_idle(300, cycles);
		check_val("clear_sweep_cycles", 32'd256, 32'(34 + cycles));
		read_counters();
		scan_predict();

		// Zero history shows in the entry a fresh branch trains
		rand_fetch = 1'b0;
		fetch_pc   = 32'h0000_0040;
		drive_branch(32'h0000_0040, 1'b0, 1'b1);
		drive_branch(32'h0000_0040, 1'b0, 1'b0);
		idle_cycles(3);
		rand_fetch = 1'b1;
		run_random(100);
		idle_cycles(2);
		read_counters();

		finish_run();
	end

endmodule

`default_nettype wire

//--- logic/bp_top.sv
/*
 * Branch direction predictor top level
 *  - Pattern table with history and clear sweep
 *  - Execute-side resolve stage
 *  - Control and statistics registers
 */

`timescale 1ns/1ns
`default_nettype none

module bp_top (
	input  logic                    clk,
	input  logic                    rst,

	// Fetch side
	input  logic [bp_pkg::PC_W-1:0] fetch_pc,
	output logic                    predict_taken,

	// Execute side
	input  logic                    advance,
	input  logic                    is_branch,
	input  logic [bp_pkg::PC_W-1:0] exec_pc,
	input  logic                    taken,
	input  logic                    exec_predicted,
	output logic                    mispredict,
	output logic                    busy,

	// Register bus
	input  logic                    reg_wr,
	input  logic                    reg_rd,
	input  logic [1:0]              reg_addr,
	input  logic [bp_pkg::REG_W-1:0] reg_wdata,
	output logic [bp_pkg::REG_W-1:0] reg_rdata
);

	// Resolved branch bundle
	bp_update_if upd_if ();

	// Register block steering the table
	logic enable;
	logic clear_start;

	// ========================================
	// Instances
	// ========================================

	bht_table bht_table_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.upd           (upd_if.table_side),
		.enable        (enable),
		.clear_start   (clear_start),
		.predict_taken (predict_taken),
		.busy          (busy)
	);

	bp_resolve bp_resolve_i (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.is_branch      (is_branch),
		.taken          (taken),
		.exec_predicted (exec_predicted),
		.exec_pc        (exec_pc),
		.upd            (upd_if.src),
		.mispredict     (mispredict)
	);

	// Plain address bits mapped onto the register enum
	bp_csr bp_csr_i (
		.clk         (clk),
		.rst         (rst),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.reg_addr    (bp_pkg::reg_addr_e'(reg_addr)),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.stats       (upd_if.stats_side),
		.busy        (busy),
		.enable      (enable),
		.clear_start (clear_start)
	);

endmodule

`default_nettype wire

//--- logic/bp_csr.sv
/*
 * Predictor register block
 *  - Control: enable bit and clear request
 *  - Status: busy and enable readback
 *  - Branch and mispredict event counters
 *  - Registered read data, one cycle after the strobe
 */

`timescale 1ns/1ns
`default_nettype none

module bp_csr (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      reg_wr,
	input  logic                      reg_rd,
	input  bp_pkg::reg_addr_e         reg_addr,
	input  logic [bp_pkg::REG_W-1:0]  reg_wdata,
	output logic [bp_pkg::REG_W-1:0]  reg_rdata,
	bp_update_if.stats_side           stats,
	input  logic                      busy,
	output logic                      enable,
	output logic                      clear_start
);

	logic [bp_pkg::CNT_W-1:0] branch_cnt;
	logic [bp_pkg::CNT_W-1:0] mis_cnt;

	// Write decode
	logic wr_ctrl;
	logic wr_branches;
	logic wr_mis;

	assign wr_ctrl     = reg_wr && reg_addr == bp_pkg::reg_ctrl;
	assign wr_branches = reg_wr && reg_addr == bp_pkg::reg_branches;
	assign wr_mis      = reg_wr && reg_addr == bp_pkg::reg_mispredicts;

	// ========================================
	// Control register
	// ========================================

	// Clear starts on the write edge, dropped while a sweep runs
	assign clear_start = wr_ctrl && reg_wdata[1] && !busy;

	// Predictor comes up enabled
	always_ff @(posedge clk) begin
		if (rst)
			enable <= 1'b1;
		else if (wr_ctrl)
			enable <= reg_wdata[0];
	end

	// ========================================
	// Event counters
	// ========================================

	// Any write zeroes, otherwise count resolved branches
	always_ff @(posedge clk) begin
		if (rst)
			branch_cnt <= '0;
		else if (wr_branches)
			branch_cnt <= '0;
		else if (stats.valid)
			branch_cnt <= branch_cnt + 1'b1;
	end

	// Same edge as the table write
	always_ff @(posedge clk) begin
		if (rst)
			mis_cnt <= '0;
		else if (wr_mis)
			mis_cnt <= '0;
		else if (stats.valid && stats.mispredict)
			mis_cnt <= mis_cnt + 1'b1;
	end

	// ========================================
	// Read path
	// ========================================

	// Data holds until the next read
	always_ff @(posedge clk) begin
		if (reg_rd) begin
			case (reg_addr)
				bp_pkg::reg_ctrl:        reg_rdata <= {{(bp_pkg::REG_W-1){1'b0}}, enable};
				bp_pkg::reg_status:      reg_rdata <= {{(bp_pkg::REG_W-2){1'b0}}, enable, busy};
				bp_pkg::reg_branches:    reg_rdata <= branch_cnt;
				bp_pkg::reg_mispredicts: reg_rdata <= mis_cnt;
				default:                 reg_rdata <= '0;
			endcase
		end
	end

	// Accepted clear must reach the table and raise busy
	a_clear_busy: assert property (@(posedge clk) disable iff (rst)
		clear_start |=> busy);

endmodule

`default_nettype wire

//--- logic/bp_resolve.sv
/*
 * Execute-side resolve stage
 *  - Samples one resolved branch per advance
 *  - Flags a mispredict against the carried prediction
 *  - Drives the update bundle for one cycle
 */

`timescale 1ns/1ns
`default_nettype none

module bp_resolve (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    advance,
	input  logic                    is_branch,
	input  logic                    taken,
	input  logic                    exec_predicted,
	input  logic [bp_pkg::PC_W-1:0] exec_pc,
	bp_update_if.src                upd,
	output logic                    mispredict
);

	// Write-back stage state
	logic                    wb_valid;
	logic                    wb_mis;
	logic [bp_pkg::PC_W-1:0] wb_pc;
	logic                    wb_taken;
	logic                    capture;

	// A branch leaves execute on this edge
	assign capture = advance && is_branch;

	// ========================================
	// Stage registers
	// ========================================

	// Control flags cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_mis   <= 1'b0;
		end else begin
			wb_valid <= capture;
			// Actual direction against the fetch-time guess
			wb_mis   <= capture && (taken != exec_predicted);
		end
	end

	// Branch payload loaded on capture
	always_ff @(posedge clk) begin
		if (capture) begin
			wb_pc    <= exec_pc;
			wb_taken <= taken;
		end
	end

	// ========================================
	// Outputs
	// ========================================

	assign upd.valid      = wb_valid;
	assign upd.pc         = wb_pc;
	assign upd.taken      = wb_taken;
	assign upd.mispredict = wb_mis;

	// Pulse lines up with the table update
	assign mispredict = wb_mis;

	// A flagged mispredict always carries a valid update
	a_mis_valid: assert property (@(posedge clk) disable iff (rst)
		mispredict |-> upd.valid);

endmodule

`default_nettype wire

//--- branch_history/bht_table.sv
/*
 * Pattern history table with global history
 *  - 256 two-bit ring counters, indexed by pc and history
 *  - Same-cycle prediction for the fetch address
 *  - Training from resolved branches
 *  - Clear sweep on reset or request, with busy flag
 */

`timescale 1ns/1ns
`default_nettype none

module bht_table (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [bp_pkg::PC_W-1:0] fetch_pc,
	bp_update_if.table_side         upd,
	input  logic                    enable,
	input  logic                    clear_start,
	output logic                    predict_taken,
	output logic                    busy
);

	// Counter array, no reset, the sweep initialises it
	bp_pkg::ctr_e pht [bp_pkg::BHT_DEPTH];

	// Global history, newest outcome in bit 0
	logic [bp_pkg::GHR_W-1:0] ghr;

	// Sweep position
	logic [bp_pkg::BHT_AW-1:0] sweep_idx;

	logic [bp_pkg::BHT_AW-1:0] rd_idx;
	logic [bp_pkg::BHT_AW-1:0] wr_idx;
	bp_pkg::ctr_e              rd_ctr;
	bp_pkg::ctr_e              wr_ctr;
	bp_pkg::ctr_e              wr_next;
	logic                      upd_ok;

	// ========================================
	// Index and prediction
	// ========================================

	// Word address bits then the two oldest history bits
	assign rd_idx = {fetch_pc[bp_pkg::BHT_AW-1:2], ghr[bp_pkg::GHR_W-1:bp_pkg::GHR_W-2]};
	// Write side uses history before this update shifts it
	assign wr_idx = {upd.pc[bp_pkg::BHT_AW-1:2], ghr[bp_pkg::GHR_W-1:bp_pkg::GHR_W-2]};

	assign rd_ctr = pht[rd_idx];
	assign wr_ctr = pht[wr_idx];

	// Taken for weak_t and strong_t, suppressed when off or sweeping
	assign predict_taken = enable && !busy &&
		(rd_ctr == bp_pkg::weak_t || rd_ctr == bp_pkg::strong_t);

	// Updates are dropped during a sweep
	assign upd_ok = upd.valid && !busy;

	// ========================================
	// Ring saturating step
	// ========================================

	function automatic bp_pkg::ctr_e ctr_step(input bp_pkg::ctr_e cur, input logic tk);
		bp_pkg::ctr_e nxt;
		nxt = cur;
		if (tk) begin
			// Toward strong_t, hold there
			case (cur)
				bp_pkg::strong_nt: nxt = bp_pkg::weak_nt;
				bp_pkg::weak_nt:   nxt = bp_pkg::weak_t;
				bp_pkg::weak_t:    nxt = bp_pkg::strong_t;
				default:           nxt = bp_pkg::strong_t;
			endcase
		end else begin
			// Toward strong_nt, hold there
			case (cur)
				bp_pkg::strong_t: nxt = bp_pkg::weak_t;
				bp_pkg::weak_t:   nxt = bp_pkg::weak_nt;
				bp_pkg::weak_nt:  nxt = bp_pkg::strong_nt;
				default:          nxt = bp_pkg::strong_nt;
			endcase
		end
		return nxt;
	endfunction

	assign wr_next = ctr_step(wr_ctr, upd.taken);

	// ========================================
	// Sweep control and history
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			// Reset runs a full sweep
			busy      <= 1'b1;
			sweep_idx <= '0;
			ghr       <= '0;
		end else if (busy) begin
			sweep_idx <= sweep_idx + 1'b1;
			// Last entry written this cycle
			if (sweep_idx == bp_pkg::BHT_AW'(bp_pkg::BHT_DEPTH - 1))
				busy <= 1'b0;
		end else if (clear_start) begin
			busy      <= 1'b1;
			sweep_idx <= '0;
			ghr       <= '0;
		end else if (upd_ok) begin
			// Shift left, newest outcome enters at bit 0
			ghr <= {ghr[bp_pkg::GHR_W-2:0], upd.taken};
		end
	end

	// Table writes, sweep has priority over training
	always_ff @(posedge clk) begin
		if (busy)
			pht[sweep_idx] <= bp_pkg::weak_t;
		else if (upd_ok)
			pht[wr_idx] <= wr_next;
	end

	// ========================================
	// Checks
	// ========================================

	// Register block must hold back clears during a sweep
	a_no_clear_busy: assert property (@(posedge clk) disable iff (rst)
		clear_start |-> !busy);

	// Idle sweep counter rests at entry 0, ready for the next clear
	a_sweep_idle: assert property (@(posedge clk) disable iff (rst)
		!busy |-> sweep_idx == '0);

endmodule

`default_nettype wire

//--- common/bp_update_if.sv
/*
 * Resolved branch update bundle
 *  - src: driven by the execute-side resolve stage
 *  - table_side: pattern table and history training
 *  - stats_side: branch and mispredict counting
 */

`timescale 1ns/1ns
`default_nettype none

interface bp_update_if;

	// One resolved branch, valid for a single cycle
	logic                    valid;
	logic [bp_pkg::PC_W-1:0] pc;
	logic                    taken;
	logic                    mispredict;

	modport src (output valid, output pc, output taken, output mispredict);

	// Table only needs the address and direction
	modport table_side (input valid, input pc, input taken);

	// Counters only need the event strobes
	modport stats_side (input valid, input mispredict);

endinterface

`default_nettype wire

//--- common/bp_pkg.sv
/*
 * Branch predictor shared definitions
 *  - PC, history, table index and event counter widths
 *  - Two-bit counter ring encoding
 *  - Register map of the control block
 */

`default_nettype none

package bp_pkg;

	// ========================================
	// Widths and sizes
	// ========================================

	// Program counter width
	localparam int PC_W = 32;
	// Global history length, two oldest bits go into the index
	localparam int GHR_W = 3;
	// Table index: pc[7:2] followed by ghr[2:1]
	localparam int BHT_AW = 8;
	localparam int BHT_DEPTH = 256;
	// Event counters and register bus
	localparam int CNT_W = 32;
	localparam int REG_W = 32;

	// ========================================
	// Encodings
	// ========================================

	// Counter states form a ring: 2 -> 3 -> 0 -> 1 going taken
	// Top bit clear means predict taken
	typedef enum logic [1:0] {
		weak_t    = 2'd0,
		strong_t  = 2'd1,
		strong_nt = 2'd2,
		weak_nt   = 2'd3
	} ctr_e;

	// Register addresses
	typedef enum logic [1:0] {
		reg_ctrl        = 2'd0,
		reg_status      = 2'd1,
		reg_branches    = 2'd2,
		reg_mispredicts = 2'd3
	} reg_addr_e;

endpackage

`default_nettype wire
